// ==== test/order_book_stimulus.txt ====
# op side stock qty price id | expected hit best_bid best_ask | ready low cycles
# op 0 add 1 cancel 2 execute, side 0 bid 1 ask, best prices are for the line's stock
0 0 1 100 1000 101 1 1000 0 0
0 0 1 50 1020 102 1 1020 0 0
0 0 1 70 1010 103 1 1020 0 0
0 1 1 40 1050 201 1 1020 1050 0
0 1 1 60 1040 202 1 1020 1040 0
0 1 1 30 1060 203 1 1020 1040 0
0 0 2 10 500 301 1 500 0 0
0 1 2 20 520 401 1 500 520 0
0 0 2 15 505 302 1 505 520 3
1 0 1 0 0 999 0 1020 1040 0
1 0 1 0 0 102 1 1010 1040 0
1 1 1 0 0 202 1 1010 1050 4
2 0 1 30 0 103 1 1010 1050 0
2 0 1 40 0 103 1 1000 1050 0
2 1 1 10 0 201 1 1000 1050 0
2 1 1 100 0 201 1 1000 1060 2
2 0 2 5 0 777 0 505 520 0
0 1 3 1 2050 501 1 0 2050 0
0 1 3 1 2030 502 1 0 2030 0
0 1 3 1 2070 503 1 0 2030 0
0 1 3 1 2010 504 1 0 2010 0
0 1 3 1 2090 505 1 0 2010 0
0 1 3 1 2020 506 1 0 2010 0
0 1 3 1 2040 507 1 0 2010 0
0 1 3 1 2060 508 1 0 2010 0
0 1 3 1 2000 509 0 0 2010 2
1 1 3 0 0 504 1 0 2020 0
1 1 3 0 0 506 1 0 2030 0
1 1 3 0 0 501 1 0 2030 0
1 1 3 0 0 502 1 0 2040 0
1 1 3 0 0 507 1 0 2060 0
1 1 3 0 0 508 1 0 2070 0
1 1 3 0 0 503 1 0 2090 0
1 1 3 0 0 505 1 0 0 0

// ==== src.f ====
+incdir+source
source/order_book_pkg.sv
source/book_store.sv
source/best_price_tracker.sv
source/order_ctrl.sv
source/order_book_top.sv
test/order_book_tb.sv

// ==== test/order_book_tb.sv ====
/* testbench for the order book, replays commands from the stimulus file
   and checks the hit flag and best prices against its expected columns */
`timescale 1ns/1ps
`default_nettype none

`include "order_book_cfg.svh"

module order_book_tb;

    localparam int IDLE_TIMEOUT   = 200;
    localparam int RESULT_TIMEOUT = 200;

    logic                         i_clk;
    logic                         i_reset_n;
    logic                         i_data_valid;
    order_book_pkg::order_op_e    i_op;
    order_book_pkg::order_side_e  i_side;
    logic [`OB_STOCK_W-1:0]       i_stock_id;
    logic [`OB_QTY_W-1:0]         i_quantity;
    logic [`OB_PRICE_W-1:0]       i_price;
    logic [`OB_ID_W-1:0]          i_order_id;
    logic                         i_trading_logic_ready;
    logic                         o_book_busy;
    logic                         o_data_valid;
    logic                         o_hit;
    logic [`OB_PRICE_W-1:0]       o_best_bid;
    logic [`OB_PRICE_W-1:0]       o_best_ask;

    int tests_run;
    int tests_failed;
    int error_count;
    bit aborted;

    order_book_top i_order_book_top (
        .i_clk                 (i_clk),
        .i_reset_n             (i_reset_n),
        .i_data_valid          (i_data_valid),
        .i_op                  (i_op),
        .i_side                (i_side),
        .i_stock_id            (i_stock_id),
        .i_quantity            (i_quantity),
        .i_price               (i_price),
        .i_order_id            (i_order_id),
        .i_trading_logic_ready (i_trading_logic_ready),
        .o_book_busy           (o_book_busy),
        .o_data_valid          (o_data_valid),
        .o_hit                 (o_hit),
        .o_best_bid            (o_best_bid),
        .o_best_ask            (o_best_ask)
    );

    initial begin
        i_clk = 1'b0;
        forever begin
            #10 i_clk = ~i_clk;
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        assert (actual === expected) else begin
            $display("ERROR at %0d ns: %s expected %0d, got %0d",
                     $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_result(input int exp_hit, input int exp_bid, input int exp_ask);
        check_value("o_hit", o_hit, exp_hit);
        check_value("o_best_bid", o_best_bid, exp_bid);
        check_value("o_best_ask", o_best_ask, exp_ask);
    endtask

    task automatic wait_idle(output bit timed_out);
        int cycles;
        cycles = 0;
        while (o_book_busy !== 1'b0 && cycles < IDLE_TIMEOUT) begin
            @(negedge i_clk);
            cycles++;
        end
        timed_out = (o_book_busy !== 1'b0);
    endtask

    task automatic wait_result(output bit timed_out);
        int cycles;
        cycles = 0;
        while (o_data_valid !== 1'b1 && cycles < RESULT_TIMEOUT) begin
            @(negedge i_clk);
            cycles++;
        end
        timed_out = (o_data_valid !== 1'b1);
    endtask

    task automatic run_command(input int line_no, input int op, input int side,
                               input int stock, input int qty, input int price,
                               input int id, input int exp_hit, input int exp_bid,
                               input int exp_ask, input int hold);
        int errors_before;
        bit timed_out;
        errors_before = error_count;
        wait_idle(timed_out);
        if (timed_out) begin
            $display("book stayed busy too long before stimulus line %0d", line_no);
            error_count++;
            aborted = 1'b1;
        end else begin
            i_op                  = order_book_pkg::order_op_e'(op[1:0]);
            i_side                = order_book_pkg::order_side_e'(side[0]);
            i_stock_id            = stock[`OB_STOCK_W-1:0];
            i_quantity            = qty[`OB_QTY_W-1:0];
            i_price               = price;
            i_order_id            = id;
            i_data_valid          = 1'b1;
            i_trading_logic_ready = (hold == 0);
            @(negedge i_clk);
            i_data_valid = 1'b0;
            wait_result(timed_out);
            if (timed_out) begin
                $display("no result came back for stimulus line %0d", line_no);
                error_count++;
                aborted = 1'b1;
            end else begin
                check_result(exp_hit, exp_bid, exp_ask);
                // the result has to sit still while ready is held low
                for (int c = 0; c < hold; c++) begin
                    @(negedge i_clk);
                    check_value("o_data_valid", o_data_valid, 1);
                    check_value("o_book_busy", o_book_busy, 1);
                    check_result(exp_hit, exp_bid, exp_ask);
                end
                i_trading_logic_ready = 1'b1;
                @(negedge i_clk);
                check_value("o_data_valid", o_data_valid, 0);
                check_value("o_book_busy", o_book_busy, 0);
            end
        end
        tests_run++;
        if (error_count != errors_before) begin
            tests_failed++;
        end
        $display("test %0d line %0d op %0d side %0d stock %0d id %0d: %s", tests_run,
                 line_no, op, side, stock, id, (error_count == errors_before) ? "pass" : "FAIL");
    endtask

    initial begin
        int fd;
        int n;
        int line_no;
        int errors_before;
        int f_op, f_side, f_stock, f_qty, f_price, f_id;
        int f_hit, f_bid, f_ask, f_hold;
        logic [8*256-1:0] line_buf;

        tests_run             = 0;
        tests_failed          = 0;
        error_count           = 0;
        aborted               = 1'b0;
        i_reset_n             = 1'b0;
        i_data_valid          = 1'b0;
        i_op                  = order_book_pkg::OP_NONE;
        i_side                = order_book_pkg::SIDE_BID;
        i_stock_id            = '0;
        i_quantity            = '0;
        i_price               = '0;
        i_order_id            = '0;
        i_trading_logic_ready = 1'b1;

        repeat (2) @(negedge i_clk);
        i_reset_n = 1'b1;

        // state straight after reset
        errors_before = error_count;
        check_value("o_book_busy", o_book_busy, 0);
        check_value("o_data_valid", o_data_valid, 0);
        check_value("o_best_bid", o_best_bid, 0);
        check_value("o_best_ask", o_best_ask, 0);
        tests_run++;
        if (error_count != errors_before) begin
            tests_failed++;
        end
        $display("test %0d reset state: %s", tests_run,
                 (error_count == errors_before) ? "pass" : "FAIL");

        fd = $fopen("test/order_book_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file test/order_book_stimulus.txt");
            error_count++;
        end else begin
            line_no = 0;
            while (!aborted && $fgets(line_buf, fd) != 0) begin
                line_no++;
                n = $sscanf(line_buf, "%d %d %d %d %d %d %d %d %d %d", f_op, f_side,
                            f_stock, f_qty, f_price, f_id, f_hit, f_bid, f_ask, f_hold);
                // comment lines parse to nothing
                if (n == 10) begin
                    run_command(line_no, f_op, f_side, f_stock, f_qty, f_price, f_id,
                                f_hit, f_bid, f_ask, f_hold);
                end else if (n > 0) begin
                    $display("stimulus line %0d has %0d columns instead of 10", line_no, n);
                    error_count++;
                end
            end
            $fclose(fd);
        end

        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, error_count);
        if (error_count == 0 && tests_run > 1) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== source/order_book_top.sv ====
/* limit order book top level, joining the command FSM, the order store
   and the best price tracker */
`timescale 1ns/1ps
`default_nettype none

`include "order_book_cfg.svh"

module order_book_top (
    input  wire                               i_clk,
    input  wire                               i_reset_n,
    input  wire                               i_data_valid,
    input  wire order_book_pkg::order_op_e    i_op,
    input  wire order_book_pkg::order_side_e  i_side,
    input  wire [`OB_STOCK_W-1:0]             i_stock_id,
    input  wire [`OB_QTY_W-1:0]               i_quantity,
    input  wire [`OB_PRICE_W-1:0]             i_price,
    input  wire [`OB_ID_W-1:0]                i_order_id,
    input  wire                               i_trading_logic_ready,
    output logic                              o_book_busy,
    output logic                              o_data_valid,
    output logic                              o_hit,
    output logic [`OB_PRICE_W-1:0]            o_best_bid,
    output logic [`OB_PRICE_W-1:0]            o_best_ask
);

    // controller to store
    order_book_pkg::order_side_e side;
    logic [`OB_STOCK_W-1:0]      stock;
    logic [`OB_SLOT_W-1:0]       rd_slot;
    logic                        append;
    order_book_pkg::order_info_u info;
    logic [`OB_PRICE_W-1:0]      price;
    logic [`OB_ID_W-1:0]         id;
    logic                        set_qty;
    logic [`OB_QTY_W-1:0]        new_qty;
    logic                        remove;

    // store back to controller and tracker
    logic [`OB_COUNT_W-1:0]      count;
    logic                        full;
    order_book_pkg::order_info_u rd_info;
    logic [`OB_ID_W-1:0]         rd_id;
    logic [`OB_PRICE_W-1:0]      scan_price;

    // tracker handshake
    logic [`OB_SLOT_W-1:0]       scan_slot;
    logic                        scan_start;
    logic                        scan_done;

    order_ctrl i_order_ctrl (
        .i_clk                 (i_clk),
        .i_reset_n             (i_reset_n),
        .i_data_valid          (i_data_valid),
        .i_op                  (i_op),
        .i_side                (i_side),
        .i_stock_id            (i_stock_id),
        .i_quantity            (i_quantity),
        .i_price               (i_price),
        .i_order_id            (i_order_id),
        .i_trading_logic_ready (i_trading_logic_ready),
        .i_count               (count),
        .i_full                (full),
        .i_rd_info             (rd_info),
        .i_rd_id               (rd_id),
        .i_scan_done           (scan_done),
        .o_side                (side),
        .o_stock               (stock),
        .o_rd_slot             (rd_slot),
        .o_append              (append),
        .o_info                (info),
        .o_price               (price),
        .o_id                  (id),
        .o_set_qty             (set_qty),
        .o_new_qty             (new_qty),
        .o_remove              (remove),
        .o_scan_start          (scan_start),
        .o_book_busy           (o_book_busy),
        .o_data_valid          (o_data_valid),
        .o_hit                 (o_hit)
    );

    // read price at the search slot is not needed by the controller
    book_store i_book_store (
        .i_clk        (i_clk),
        .i_reset_n    (i_reset_n),
        .i_side       (side),
        .i_stock      (stock),
        .i_append     (append),
        .i_info       (info),
        .i_price      (price),
        .i_id         (id),
        .i_rd_slot    (rd_slot),
        .i_set_qty    (set_qty),
        .i_new_qty    (new_qty),
        .i_remove     (remove),
        .i_scan_slot  (scan_slot),
        .o_count      (count),
        .o_full       (full),
        .o_rd_info    (rd_info),
        .o_rd_price   (),
        .o_rd_id      (rd_id),
        .o_scan_price (scan_price)
    );

    best_price_tracker i_best_price_tracker (
        .i_clk         (i_clk),
        .i_reset_n     (i_reset_n),
        .i_start       (scan_start),
        .i_side        (side),
        .i_stock       (stock),
        .i_count       (count),
        .i_scan_price  (scan_price),
        .i_query_stock (i_stock_id),
        .o_scan_slot   (scan_slot),
        .o_done        (scan_done),
        .o_best_bid    (o_best_bid),
        .o_best_ask    (o_best_ask)
    );

endmodule

`default_nettype wire

// ==== source/order_ctrl.sv ====
/* command FSM: takes a parser command, searches by id, updates the
   store, starts the rescan and holds the result for the trading logic */
`timescale 1ns/1ps
`default_nettype none

`include "order_book_cfg.svh"

module order_ctrl (
    input  wire                               i_clk,
    input  wire                               i_reset_n,
    input  wire                               i_data_valid,
    input  wire order_book_pkg::order_op_e    i_op,
    input  wire order_book_pkg::order_side_e  i_side,
    input  wire [`OB_STOCK_W-1:0]             i_stock_id,
    input  wire [`OB_QTY_W-1:0]               i_quantity,
    input  wire [`OB_PRICE_W-1:0]             i_price,
    input  wire [`OB_ID_W-1:0]                i_order_id,
    input  wire                               i_trading_logic_ready,
    input  wire [`OB_COUNT_W-1:0]             i_count,
    input  wire                               i_full,
    input  wire order_book_pkg::order_info_u  i_rd_info,
    input  wire [`OB_ID_W-1:0]                i_rd_id,
    input  wire                               i_scan_done,
    output order_book_pkg::order_side_e       o_side,
    output logic [`OB_STOCK_W-1:0]            o_stock,
    output logic [`OB_SLOT_W-1:0]             o_rd_slot,
    output logic                              o_append,
    output order_book_pkg::order_info_u       o_info,
    output logic [`OB_PRICE_W-1:0]            o_price,
    output logic [`OB_ID_W-1:0]               o_id,
    output logic                              o_set_qty,
    output logic [`OB_QTY_W-1:0]              o_new_qty,
    output logic                              o_remove,
    output logic                              o_scan_start,
    output logic                              o_book_busy,
    output logic                              o_data_valid,
    output logic                              o_hit
);

    localparam logic [2:0] ST_IDLE   = 3'd0;
    localparam logic [2:0] ST_SEARCH = 3'd1;
    localparam logic [2:0] ST_UPDATE = 3'd2;
    localparam logic [2:0] ST_SCAN   = 3'd3;
    localparam logic [2:0] ST_DONE   = 3'd4;

    logic [2:0]                  state_q;
    logic [`OB_COUNT_W-1:0]      slot_q;
    logic                        hit_q;

    // latched command
    order_book_pkg::order_op_e   op_q;
    order_book_pkg::order_side_e side_q;
    logic [`OB_STOCK_W-1:0]      stock_q;
    logic [`OB_QTY_W-1:0]        qty_q;
    logic [`OB_PRICE_W-1:0]      price_q;
    logic [`OB_ID_W-1:0]         id_q;

    logic                        accept;
    logic                        in_update;
    logic                        is_add;
    logic                        exec_all;

    assign accept    = (state_q == ST_IDLE) && i_data_valid &&
                       (i_op != order_book_pkg::OP_NONE);
    assign in_update = (state_q == ST_UPDATE);
    assign is_add    = (op_q == order_book_pkg::OP_ADD);

    // executed quantity covers what is left on the order
    assign exec_all  = (qty_q >= i_rd_info.fields.qty);

    always_comb begin
        o_info              = '0;
        o_info.fields.stock = stock_q;
        o_info.fields.op    = op_q;
        o_info.fields.qty   = qty_q;
    end

    assign o_side    = side_q;
    assign o_stock   = stock_q;
    assign o_rd_slot = slot_q[`OB_SLOT_W-1:0];
    assign o_price   = price_q;
    assign o_id      = id_q;

    // all store writes happen in the single update cycle
    assign o_append  = in_update && is_add && !i_full;
    assign o_remove  = in_update && !is_add &&
                       ((op_q == order_book_pkg::OP_CANCEL) || exec_all);
    assign o_set_qty = in_update && (op_q == order_book_pkg::OP_EXECUTE) && !exec_all;
    assign o_new_qty = i_rd_info.fields.qty - qty_q;

    // a rejected add leaves the book untouched, so no rescan
    assign o_scan_start = in_update && !(is_add && i_full);

    assign o_book_busy  = (state_q != ST_IDLE);
    assign o_data_valid = (state_q == ST_DONE);
    assign o_hit        = hit_q;

    always_ff @(posedge i_clk) begin
        if (accept) begin
            op_q    <= i_op;
            side_q  <= i_side;
            stock_q <= i_stock_id;
            qty_q   <= i_quantity;
            price_q <= i_price;
            id_q    <= i_order_id;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            state_q <= ST_IDLE;
            slot_q  <= '0;
            hit_q   <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (accept) begin
                        hit_q   <= 1'b0;
                        slot_q  <= '0;
                        state_q <= (i_op == order_book_pkg::OP_ADD) ? ST_UPDATE : ST_SEARCH;
                    end
                end
                ST_SEARCH: begin
                    // walked past the last live order without a match
                    if (slot_q >= i_count) begin
                        state_q <= ST_DONE;
                    end else if (i_rd_id == id_q) begin
                        hit_q   <= 1'b1;
                        state_q <= ST_UPDATE;
                    end else begin
                        slot_q <= slot_q + 1'b1;
                    end
                end
                ST_UPDATE: begin
                    if (is_add) begin
                        hit_q <= !i_full;
                    end
                    state_q <= (is_add && i_full) ? ST_DONE : ST_SCAN;
                end
                ST_SCAN: begin
                    if (i_scan_done) begin
                        state_q <= ST_DONE;
                    end
                end
                ST_DONE: begin
                    if (i_trading_logic_ready) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/best_price_tracker.sv ====
/* best price scan over one side of one stock, with a per-stock cache
   of the best bid and best ask */
`timescale 1ns/1ps
`default_nettype none

`include "order_book_cfg.svh"

module best_price_tracker (
    input  wire                               i_clk,
    input  wire                               i_reset_n,
    input  wire                               i_start,
    input  wire order_book_pkg::order_side_e  i_side,
    input  wire [`OB_STOCK_W-1:0]             i_stock,
    input  wire [`OB_COUNT_W-1:0]             i_count,
    input  wire [`OB_PRICE_W-1:0]             i_scan_price,
    input  wire [`OB_STOCK_W-1:0]             i_query_stock,
    output logic [`OB_SLOT_W-1:0]             o_scan_slot,
    output logic                              o_done,
    output logic [`OB_PRICE_W-1:0]            o_best_bid,
    output logic [`OB_PRICE_W-1:0]            o_best_ask
);

    logic                   active_q;
    logic [`OB_COUNT_W-1:0] slot_q;
    logic [`OB_PRICE_W-1:0] best_q;
    logic [`OB_PRICE_W-1:0] bid_cache [`OB_NUM_STOCKS];
    logic [`OB_PRICE_W-1:0] ask_cache [`OB_NUM_STOCKS];
    logic                   better;
    logic [`OB_PRICE_W-1:0] result;

    assign o_scan_slot = slot_q[`OB_SLOT_W-1:0];

    // every live slot has been looked at
    assign o_done = active_q && (slot_q == i_count);

    // highest price wins on the bid side, lowest on the ask side
    always_comb begin
        if (i_side == order_book_pkg::SIDE_BID) begin
            better = (i_scan_price > best_q);
        end else begin
            better = (i_scan_price < best_q);
        end
    end

    // an empty side reports zero
    assign result = (i_count == '0) ? '0 : best_q;

    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            active_q <= 1'b0;
            slot_q   <= '0;
            for (int st = 0; st < `OB_NUM_STOCKS; st++) begin
                bid_cache[st] <= '0;
                ask_cache[st] <= '0;
            end
        end else if (!active_q) begin
            if (i_start) begin
                active_q <= 1'b1;
                slot_q   <= '0;
            end
        end else if (o_done) begin
            active_q <= 1'b0;
            if (i_side == order_book_pkg::SIDE_BID) begin
                bid_cache[i_stock] <= result;
            end else begin
                ask_cache[i_stock] <= result;
            end
        end else begin
            slot_q <= slot_q + 1'b1;
        end
    end

    // running best is seeded so the first live slot always wins
    always_ff @(posedge i_clk) begin
        if (!active_q && i_start) begin
            best_q <= (i_side == order_book_pkg::SIDE_BID) ? '0 : '1;
        end else if (active_q && !o_done && better) begin
            best_q <= i_scan_price;
        end
    end

    assign o_best_bid = bid_cache[i_query_stock];
    assign o_best_ask = ask_cache[i_query_stock];

endmodule

`default_nettype wire

// ==== source/book_store.sv ====
/* order storage for both sides of every stock, three words per order,
   with append, quantity rewrite and remove with shift-down */
`timescale 1ns/1ps
`default_nettype none

`include "order_book_cfg.svh"

module book_store (
    input  wire                                i_clk,
    input  wire                                i_reset_n,
    input  wire order_book_pkg::order_side_e   i_side,
    input  wire [`OB_STOCK_W-1:0]              i_stock,
    input  wire                                i_append,
    input  wire order_book_pkg::order_info_u   i_info,
    input  wire [`OB_PRICE_W-1:0]              i_price,
    input  wire [`OB_ID_W-1:0]                 i_id,
    input  wire [`OB_SLOT_W-1:0]               i_rd_slot,
    input  wire                                i_set_qty,
    input  wire [`OB_QTY_W-1:0]                i_new_qty,
    input  wire                                i_remove,
    input  wire [`OB_SLOT_W-1:0]               i_scan_slot,
    output logic [`OB_COUNT_W-1:0]             o_count,
    output logic                               o_full,
    output order_book_pkg::order_info_u        o_rd_info,
    output logic [`OB_PRICE_W-1:0]             o_rd_price,
    output logic [`OB_ID_W-1:0]                o_rd_id,
    output logic [`OB_PRICE_W-1:0]             o_scan_price
);

    // indexed by side, stock, slot
    order_book_pkg::order_info_u info_mem  [2][`OB_NUM_STOCKS][`OB_BOOK_DEPTH];
    logic [`OB_PRICE_W-1:0]      price_mem [2][`OB_NUM_STOCKS][`OB_BOOK_DEPTH];
    logic [`OB_ID_W-1:0]         id_mem    [2][`OB_NUM_STOCKS][`OB_BOOK_DEPTH];

    // live orders per side and stock
    logic [`OB_COUNT_W-1:0]      count     [2][`OB_NUM_STOCKS];

    logic [`OB_SLOT_W-1:0]       wr_slot;

    assign o_count = count[i_side][i_stock];
    assign o_full  = (o_count == `OB_COUNT_W'(`OB_BOOK_DEPTH));

    // next free slot while the side is not full
    assign wr_slot = o_count[`OB_SLOT_W-1:0];

    // search port for the controller, scan port for the tracker
    assign o_rd_info    = info_mem[i_side][i_stock][i_rd_slot];
    assign o_rd_price   = price_mem[i_side][i_stock][i_rd_slot];
    assign o_rd_id      = id_mem[i_side][i_stock][i_rd_slot];
    assign o_scan_price = price_mem[i_side][i_stock][i_scan_slot];

    always_ff @(posedge i_clk) begin
        if (i_append) begin
            info_mem[i_side][i_stock][wr_slot]  <= i_info;
            price_mem[i_side][i_stock][wr_slot] <= i_price;
            id_mem[i_side][i_stock][wr_slot]    <= i_id;
        end else if (i_set_qty) begin
            info_mem[i_side][i_stock][i_rd_slot].fields.qty <= i_new_qty;
        end else if (i_remove) begin
            // everything above the removed slot moves down one place
            for (int s = 0; s < `OB_BOOK_DEPTH - 1; s++) begin
                if (s >= int'(i_rd_slot)) begin
                    info_mem[i_side][i_stock][s]  <= info_mem[i_side][i_stock][s + 1];
                    price_mem[i_side][i_stock][s] <= price_mem[i_side][i_stock][s + 1];
                    id_mem[i_side][i_stock][s]    <= id_mem[i_side][i_stock][s + 1];
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            for (int sd = 0; sd < 2; sd++) begin
                for (int st = 0; st < `OB_NUM_STOCKS; st++) begin
                    count[sd][st] <= '0;
                end
            end
        end else if (i_append) begin
            count[i_side][i_stock] <= o_count + 1'b1;
        end else if (i_remove) begin
            count[i_side][i_stock] <= o_count - 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== source/order_book_pkg.sv ====
/* order book types: operation codes, book side and the order info word */
`default_nettype none

package order_book_pkg;

    // code 3 is carried on the bus but does nothing
    typedef enum logic [1:0] {
        OP_ADD     = 2'd0,
        OP_CANCEL  = 2'd1,
        OP_EXECUTE = 2'd2,
        OP_NONE    = 2'd3
    } order_op_e;

    typedef enum logic {
        SIDE_BID = 1'b0,
        SIDE_ASK = 1'b1
    } order_side_e;

    // info word as stored in the book, or split into its fields
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [11:0] spare;
            logic [1:0]  stock;
            order_op_e   op;
            logic [15:0] qty;
        } fields;
    } order_info_u;

endpackage

`default_nettype wire

// ==== source/order_book_cfg.svh ====
/* order book sizing for stocks, book depth and the order field widths */
`ifndef ORDER_BOOK_CFG_SVH
`define ORDER_BOOK_CFG_SVH

// book shape
`define OB_NUM_STOCKS 4
`define OB_STOCK_W    2
`define OB_BOOK_DEPTH 8
`define OB_SLOT_W     3
// count runs 0 to OB_BOOK_DEPTH, so one bit wider than a slot index
`define OB_COUNT_W    4

// order fields
`define OB_PRICE_W    32
`define OB_QTY_W      16
`define OB_ID_W       32

`endif
